// File: design/bus_decode.sv
`default_nettype none

module bus_decode (
    input  logic                 clk,
    input  logic                 nreset,
    input  periph_pkg::bus_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 room,
    output periph_pkg::access_t  acc,
    output logic                 acc_valid
);

    periph_pkg::access_t dec;
    logic                fire;

    assign req_ready = room;
    assign fire      = req_valid && req_ready;

    // Split the request into region, word index and write flag
    always_comb begin
        dec.region   = req.addr[periph_pkg::sel_lsb +: periph_pkg::sel_bits];
        // Byte address, low two bits ignored
        dec.word     = req.addr[2 +: periph_pkg::ram_addr_bits];
        dec.wmask    = req.wmask;
        dec.wdata    = req.wdata;
        dec.is_write = |req.wmask;
        case (dec.region)
            periph_pkg::region_ram,
            periph_pkg::region_time,
            periph_pkg::region_timer,
            periph_pkg::region_ports: begin
                dec.err = 1'b0;
            end
            default: begin
                dec.err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            acc <= dec;
        end
    end

endmodule

`default_nettype wire

// File: design/byte_ram.sv
`default_nettype none

module byte_ram #(
    parameter int addr_bits = periph_pkg::ram_addr_bits
) (
    input  logic                clk,
    input  periph_pkg::access_t acc,
    input  logic                acc_valid,
    output logic [31:0]         rdata
);

    localparam int depth = 1 << addr_bits;

    logic                 sel;
    logic [addr_bits-1:0] idx;

    assign sel = acc_valid && !acc.err && acc.region == periph_pkg::region_ram;
    assign idx = acc.word[addr_bits-1:0];

    // One memory per byte lane
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] mem [depth];
        logic [7:0] rd_byte;

        always_ff @(posedge clk) begin
            if (sel) begin
                if (acc.wmask[lane]) begin
                    mem[idx] <= acc.wdata[8*lane +: 8];
                end
                // Old contents when written
                rd_byte <= mem[idx];
            end
        end

        assign rdata[8*lane +: 8] = rd_byte;
    end

endmodule

`default_nettype wire

// File: design/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // Region selector in the top address bits
    localparam int sel_lsb  = 27;
    localparam int sel_bits = 5;

    localparam logic [sel_bits-1:0] region_ram    = 5'h02;
    localparam logic [sel_bits-1:0] region_time   = 5'h1B;
    localparam logic [sel_bits-1:0] region_timer  = 5'h1C;
    localparam logic [sel_bits-1:0] region_ports  = 5'h1F;

    // 2048 words of RAM
    localparam int ram_addr_bits = 11;

    // Clocks per timer tick
    localparam int tick_div = 8;

    localparam int rsp_depth = 4;

    // Bus request, any mask bit set makes it a write
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } bus_rsp_t;

    // Decoded access handed to the region blocks
    typedef struct packed {
        logic [sel_bits-1:0]      region;
        logic [ram_addr_bits-1:0] word;
        logic [3:0]               wmask;
        logic [31:0]              wdata;
        logic                     is_write;
        logic                     err;
    } access_t;

    // Access plus valid, as held in a pipeline slot
    typedef struct packed {
        logic    valid;
        access_t access;
    } access_slot_t;

endpackage

`default_nettype wire

// File: design/periph_top.sv
`default_nettype none

module periph_top (
    input  logic                 clk,
    input  logic                 nreset,
    input  periph_pkg::bus_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output periph_pkg::bus_rsp_t rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output logic                 irq,
    input  logic                 irq_ack,
    input  logic [4:0]           buttons,
    input  logic                 scl_in,
    input  logic                 sda_in,
    output logic                 led,
    output logic                 scl,
    output logic                 sda
);

    periph_pkg::access_t acc;
    logic                acc_valid;
    logic                room;
    logic [31:0]         ram_rdata;
    logic [31:0]         time_value;
    logic [31:0]         remaining;
    logic [6:0]          snapshot;

    bus_decode i_bus_decode (
        .clk       (clk),
        .nreset    (nreset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .room      (room),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    // Execute blocks all see the same registered access
    byte_ram #(
        .addr_bits (periph_pkg::ram_addr_bits)
    ) i_byte_ram (
        .clk       (clk),
        .acc       (acc),
        .acc_valid (acc_valid),
        .rdata     (ram_rdata)
    );

    tick_timers i_tick_timers (
        .clk        (clk),
        .nreset     (nreset),
        .acc        (acc),
        .acc_valid  (acc_valid),
        .irq_ack    (irq_ack),
        .time_value (time_value),
        .remaining  (remaining),
        .irq        (irq)
    );

    port_regs i_port_regs (
        .clk       (clk),
        .nreset    (nreset),
        .acc       (acc),
        .acc_valid (acc_valid),
        .buttons   (buttons),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .led       (led),
        .scl       (scl),
        .sda       (sda),
        .snapshot  (snapshot)
    );

    read_return i_read_return (
        .clk        (clk),
        .nreset     (nreset),
        .acc        (acc),
        .acc_valid  (acc_valid),
        .ram_rdata  (ram_rdata),
        .time_value (time_value),
        .remaining  (remaining),
        .snapshot   (snapshot),
        .room       (room),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready)
    );

endmodule

`default_nettype wire

// File: design/port_regs.sv
`default_nettype none

module port_regs (
    input  logic                clk,
    input  logic                nreset,
    input  periph_pkg::access_t acc,
    input  logic                acc_valid,
    input  logic [4:0]          buttons,
    input  logic                scl_in,
    input  logic                sda_in,
    output logic                led,
    output logic                scl,
    output logic                sda,
    output logic [6:0]          snapshot
);

    logic sel;

    assign sel = acc_valid && !acc.err && acc.region == periph_pkg::region_ports;

    // I2C lines idle high
    always_ff @(posedge clk) begin
        if (!nreset) begin
            led <= 1'b0;
            scl <= 1'b1;
            sda <= 1'b1;
        end else if (sel && acc.is_write && acc.wmask[0]) begin
            {led, scl, sda} <= acc.wdata[2:0];
        end
    end

    // con, psh, tra, trb, bak, then scl and sda
    always_ff @(posedge clk) begin
        if (sel && !acc.is_write) begin
            snapshot <= {buttons, scl_in, sda_in};
        end
    end

endmodule

`default_nettype wire

// File: design/read_return.sv
`default_nettype none

module read_return (
    input  logic                 clk,
    input  logic                 nreset,
    input  periph_pkg::access_t  acc,
    input  logic                 acc_valid,
    input  logic [31:0]          ram_rdata,
    input  logic [31:0]          time_value,
    input  logic [31:0]          remaining,
    input  logic [6:0]           snapshot,
    output logic                 room,
    output periph_pkg::bus_rsp_t rsp,
    output logic                 rsp_valid,
    input  logic                 rsp_ready
);

    localparam int ptr_bits = $clog2(periph_pkg::rsp_depth);
    localparam int cnt_bits = $clog2(periph_pkg::rsp_depth + 1);
    localparam int sum_bits = cnt_bits + 1;

    periph_pkg::access_slot_t exe_access;
    periph_pkg::bus_rsp_t     result;
    periph_pkg::bus_rsp_t     queue [periph_pkg::rsp_depth];
    logic [ptr_bits-1:0]      wr_ptr;
    logic [ptr_bits-1:0]      rd_ptr;
    logic [cnt_bits-1:0]      count;
    logic [sum_bits-1:0]      pending;
    logic                     pop;

    // Execute cycle, region blocks register their data meanwhile
    always_ff @(posedge clk) begin
        if (!nreset) begin
            exe_access.valid <= 1'b0;
        end else begin
            exe_access.valid <= acc_valid;
        end
        exe_access.access <= acc;
    end

    always_comb begin
        result.err   = exe_access.access.err;
        result.rdata = '0;
        if (!exe_access.access.err && !exe_access.access.is_write) begin
            case (exe_access.access.region)
                periph_pkg::region_ram:   result.rdata = ram_rdata;
                periph_pkg::region_time:  result.rdata = time_value;
                periph_pkg::region_timer: result.rdata = remaining;
                periph_pkg::region_ports: result.rdata = {25'd0, snapshot};
                default:                  result.rdata = '0;
            endcase
        end
    end

    assign pop       = rsp_valid && rsp_ready;
    assign rsp_valid = count != '0;
    assign rsp       = queue[rd_ptr];

    // Pointers wrap with a power of two depth
    always_ff @(posedge clk) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (exe_access.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_bits'(exe_access.valid) - cnt_bits'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (exe_access.valid) begin
            queue[wr_ptr] <= result;
        end
    end

    // Queued plus in flight, so every accepted request has a slot
    assign pending = {1'b0, count} + sum_bits'(acc_valid) + sum_bits'(exe_access.valid);
    assign room    = pending < sum_bits'(periph_pkg::rsp_depth);

endmodule

`default_nettype wire

// File: design/tick_timers.sv
`default_nettype none

module tick_timers (
    input  logic                clk,
    input  logic                nreset,
    input  periph_pkg::access_t acc,
    input  logic                acc_valid,
    input  logic                irq_ack,
    output logic [31:0]         time_value,
    output logic [31:0]         remaining,
    output logic                irq
);

    localparam int presc_bits = $clog2(periph_pkg::tick_div);
    localparam logic [presc_bits-1:0] presc_last = presc_bits'(periph_pkg::tick_div - 1);

    logic [presc_bits-1:0] presc;
    logic                  tick;
    logic                  load;
    logic                  expire;

    assign tick = presc == presc_last;
    assign load = acc_valid && !acc.err && acc.is_write
                  && acc.region == periph_pkg::region_timer;

    // Last step of a running countdown, a new load overrides it
    assign expire = tick && !load && remaining == 32'd1;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            time_value <= '0;
        end else if (tick) begin
            time_value <= time_value + 32'd1;
        end
    end

    // Zero means stopped
    always_ff @(posedge clk) begin
        if (!nreset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= acc.wdata;
        end else if (tick && remaining != '0) begin
            remaining <= remaining - 32'd1;
        end
    end

    // Interrupt latch, a new expiry wins over ack
    always_ff @(posedge clk) begin
        if (!nreset) begin
            irq <= 1'b0;
        end else if (expire) begin
            irq <= 1'b1;
        end else if (irq_ack) begin
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run with Verilator, result taken from the simulation log
verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// File: tb.f
design/periph_pkg.sv
design/bus_decode.sv
design/byte_ram.sv
design/tick_timers.sv
design/port_regs.sv
design/read_return.sv
design/periph_top.sv
testbench/periph_props.sv
testbench/periph_checker.sv
testbench/tb_top.sv

// File: testbench/periph_checker.sv
`default_nettype none

module periph_checker (
    input  logic                 clk,
    input  logic                 nreset,
    input  periph_pkg::bus_req_t req,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  periph_pkg::bus_rsp_t rsp,
    input  logic                 rsp_valid,
    input  logic                 rsp_ready,
    input  logic                 irq,
    input  logic                 irq_ack,
    input  logic [4:0]           buttons,
    input  logic                 scl_in,
    input  logic                 sda_in,
    input  logic                 led,
    input  logic                 scl,
    input  logic                 sda,
    output int                   errors,
    output int                   checks,
    output int                   outstanding
);

    localparam logic [1:0] kind_exact = 2'd0;
    localparam logic [1:0] kind_time  = 2'd1;

    typedef struct packed {
        periph_pkg::bus_rsp_t rsp;
        logic [1:0]           kind;
    } expect_t;

    expect_t     expq[$];
    logic [31:0] shadow [2048];
    int          cyc;
    int          lat_at;
    int          port_at;
    logic [2:0]  port_exp;
    logic        armed;
    int          arm_cyc;
    int          arm_n;
    logic        irq_q;
    logic        ack_q;

    initial begin
        errors = 0;
        checks = 0;
        outstanding = 0;
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = 32'd0;
        end
    end

    // Expected response from the shadow state with a tolerance on time reads
    function automatic expect_t predict_rsp(periph_pkg::bus_req_t r, logic [6:0] pins, int now);
        expect_t     e;
        logic [4:0]  region;
        int          ticks;
        region = r.addr[periph_pkg::sel_lsb +: periph_pkg::sel_bits];
        e.rsp  = '0;
        e.kind = kind_exact;
        case (region)
            periph_pkg::region_ram: begin
                if (r.wmask == 4'd0) e.rsp.rdata = shadow[r.addr[12:2]];
            end
            periph_pkg::region_time: begin
                if (r.wmask == 4'd0) begin
                    e.rsp.rdata = 32'((now + 2) / periph_pkg::tick_div);
                    e.kind = kind_time;
                end
            end
            periph_pkg::region_timer: begin
                // Loaded the cycle after the write, one step down per tick since
                if (r.wmask == 4'd0) begin
                    ticks = (now + 2) / periph_pkg::tick_div
                            - (arm_cyc + 2) / periph_pkg::tick_div;
                    if (arm_n > ticks) e.rsp.rdata = 32'(arm_n - ticks);
                end
            end
            periph_pkg::region_ports: begin
                if (r.wmask == 4'd0) e.rsp.rdata = {25'd0, pins};
            end
            default: e.rsp.err = 1'b1;
        endcase
        return e;
    endfunction

    task automatic value_error(string name, logic [31:0] expv, logic [31:0] actv);
        errors++;
        $display("CHECK FAILED %s expected %h actual %h", name, expv, actv);
    endtask

    task automatic fault(string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    always @(posedge clk) begin
        expect_t     e;
        logic [4:0]  region;
        int          diff;
        if (!nreset) begin
            cyc = 0;
            lat_at = -1;
            port_at = -1;
            armed = 1'b0;
            arm_cyc = 0;
            arm_n = 0;
            irq_q = 1'b0;
            ack_q = 1'b0;
        end else begin
            if (lat_at >= 0 && cyc == lat_at - 1 && rsp_valid) fault("response came too early");
            if (cyc == lat_at) begin
                checks++;
                if (!rsp_valid) fault("response did not arrive 2 cycles after transfer");
                lat_at = -1;
            end
            if (cyc == port_at) begin
                checks++;
                if ({led, scl, sda} != port_exp) value_error("ports_out", 32'(port_exp),
                                                             32'({led, scl, sda}));
            end
            if (rsp_valid && rsp_ready) begin
                if (expq.size() == 0) begin
                    fault("response without a request");
                end else begin
                    e = expq.pop_front();
                    checks++;
                    if (rsp.err != e.rsp.err) value_error("rsp_err", 32'(e.rsp.err),
                                                          32'(rsp.err));
                    diff = int'(rsp.rdata) - int'(e.rsp.rdata);
                    if (e.kind == kind_exact && diff != 0) begin
                        value_error("rsp_data", e.rsp.rdata, rsp.rdata);
                    end else if (e.kind == kind_time && (diff > 1 || diff < -1)) begin
                        value_error("time_value", e.rsp.rdata, rsp.rdata);
                    end
                end
            end
            if (req_valid && req_ready) begin
                region = req.addr[periph_pkg::sel_lsb +: periph_pkg::sel_bits];
                if (expq.size() == 0) lat_at = cyc + 3;
                expq.push_back(predict_rsp(req, {buttons, scl_in, sda_in}, cyc));
                if (region == periph_pkg::region_ram) begin
                    for (int l = 0; l < 4; l++) begin
                        if (req.wmask[l]) shadow[req.addr[12:2]][8*l +: 8] = req.wdata[8*l +: 8];
                    end
                end
                if (region == periph_pkg::region_ports && req.wmask[0]) begin
                    port_exp = req.wdata[2:0];
                    port_at = cyc + 2;
                end
                if (region == periph_pkg::region_timer && req.wmask != 4'd0) begin
                    armed = req.wdata != 32'd0;
                    arm_cyc = cyc;
                    arm_n = int'(req.wdata);
                end
            end
            outstanding = expq.size();
            if (outstanding > periph_pkg::rsp_depth) fault("more requests accepted than queue depth");
            if (irq && !irq_q) begin
                checks++;
                if (!armed) begin
                    fault("irq raised with no timer running");
                end else if (cyc - arm_cyc < (arm_n - 1) * periph_pkg::tick_div) begin
                    value_error("irq_delay", 32'((arm_n - 1) * periph_pkg::tick_div),
                                32'(cyc - arm_cyc));
                end
                armed = 1'b0;
            end
            if (armed && cyc - arm_cyc > (arm_n + 1) * periph_pkg::tick_div + 2) begin
                fault("irq did not arrive after the countdown");
                armed = 1'b0;
            end
            if (ack_q && irq) fault("irq not cleared by irq_ack");
            irq_q = irq;
            ack_q = irq_ack;
            cyc++;
        end
    end

endmodule

`default_nettype wire

// File: testbench/periph_props.sv
`default_nettype none

module periph_props (
    input logic                 clk,
    input logic                 nreset,
    input periph_pkg::bus_req_t req,
    input logic                 req_valid,
    input logic                 req_ready,
    input periph_pkg::bus_rsp_t rsp,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input logic                 irq,
    input logic                 led,
    input logic                 scl,
    input logic                 sda
);

    // Master holds a stalled request
    req_stable: assert property (@(posedge clk) disable iff (!nreset)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request changed while stalled");

    rsp_stable: assert property (@(posedge clk) disable iff (!nreset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while stalled");

    reset_state: assert property (@(posedge clk)
        $rose(nreset) |-> req_ready && !rsp_valid && !irq && !led && scl && sda)
        else $error("outputs not in reset state");

endmodule

bind periph_top periph_props i_periph_props (
    .clk       (clk),
    .nreset    (nreset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .irq       (irq),
    .led       (led),
    .scl       (scl),
    .sda       (sda)
);

`default_nettype wire

// File: testbench/tb_top.sv
`default_nettype none

module tb_top;

    localparam int n_ram_init  = 16;
    localparam int n_random    = 200;
    localparam int n_fill      = 8;
    // Ports, time and timer requests at the end
    localparam int n_directed  = 11;
    localparam int n_requests  = n_ram_init + n_random + n_fill + n_directed;
    // Worst case cycles per request including stalls and timer waits
    localparam int stall_bound = 40;

    logic                 clk;
    logic                 nreset;
    periph_pkg::bus_req_t req;
    logic                 req_valid;
    logic                 req_ready;
    periph_pkg::bus_rsp_t rsp;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic                 irq;
    logic                 irq_ack;
    logic [4:0]           buttons;
    logic                 scl_in;
    logic                 sda_in;
    logic                 led;
    logic                 scl;
    logic                 sda;
    int                   errors;
    int                   checks;
    int                   outstanding;
    logic [31:0]          seed;
    logic [31:0]          stall_state;
    logic [1:0]           ready_mode;

    periph_top i_periph_top (
        .clk       (clk),
        .nreset    (nreset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .irq       (irq),
        .irq_ack   (irq_ack),
        .buttons   (buttons),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .led       (led),
        .scl       (scl),
        .sda       (sda)
    );

    periph_checker i_periph_checker (
        .clk         (clk),
        .nreset      (nreset),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .buttons     (buttons),
        .scl_in      (scl_in),
        .sda_in      (sda_in),
        .led         (led),
        .scl         (scl),
        .sda         (sda),
        .errors      (errors),
        .checks      (checks),
        .outstanding (outstanding)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw(output logic [31:0] v);
        seed = lcg_next(seed);
        v = seed;
    endtask

    // Starts on a falling edge and returns on the one after the transfer
    task automatic send(logic [4:0] region, logic [10:0] word, logic [3:0] wmask,
                        logic [31:0] wdata);
        req.addr  = {region, 14'd0, word, 2'b00};
        req.wmask = wmask;
        req.wdata = wdata;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (outstanding != 0);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // 0 always ready, 1 random stalls, 2 held low
    always @(negedge clk) begin
        stall_state = lcg_next(stall_state);
        case (ready_mode)
            2'd1:    rsp_ready <= stall_state[20] | stall_state[21];
            2'd2:    rsp_ready <= 1'b0;
            default: rsp_ready <= 1'b1;
        endcase
    end

    initial begin
        repeat (n_requests * stall_bound) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        logic [4:0]  region;
        seed        = 32'h57b7;
        stall_state = 32'h57b7;
        ready_mode  = 2'd0;
        nreset      = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        rsp_ready   = 1'b1;
        irq_ack     = 1'b0;
        buttons     = 5'd0;
        scl_in      = 1'b1;
        sda_in      = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nreset = 1'b1;

        // Known contents for the RAM window one request at a time
        for (int i = 0; i < n_ram_init; i++) begin
            send(periph_pkg::region_ram, 11'(i), 4'hf, 32'd0);
            wait_idle();
        end

        ready_mode = 2'd1;
        repeat (n_random) begin
            draw(v);
            draw(w);
            if (v[27:24] != 4'hf) begin
                send(periph_pkg::region_ram, {7'd0, v[19:16]}, v[31:28], w);
            end else begin
                region = v[12:8];
                if (region == periph_pkg::region_ram || region == periph_pkg::region_time
                    || region == periph_pkg::region_timer
                    || region == periph_pkg::region_ports) begin
                    region = 5'h05;
                end
                send(region, {7'd0, v[19:16]}, v[31:28], w);
            end
        end
        wait_idle();

        // Responses held back until the queue fills
        ready_mode = 2'd2;
        fork
            begin
                for (int i = 0; i < n_fill; i++) begin
                    send(periph_pkg::region_ram, 11'(i), 4'h0, 32'd0);
                end
            end
        join_none
        repeat (40) @(negedge clk);
        ready_mode = 2'd0;
        wait fork;
        wait_idle();

        draw(v);
        buttons = v[4:0];
        scl_in  = v[5];
        sda_in  = v[6];
        send(periph_pkg::region_ports, 11'd0, 4'h1, 32'h5);
        wait_idle();
        send(periph_pkg::region_ports, 11'd0, 4'h0, 32'd0);
        wait_idle();
        buttons = ~v[4:0];
        scl_in  = ~v[5];
        send(periph_pkg::region_ports, 11'd0, 4'h1, 32'h2);
        send(periph_pkg::region_ports, 11'd0, 4'h0, 32'd0);
        wait_idle();

        send(periph_pkg::region_time, 11'd0, 4'h0, 32'd0);
        repeat (40) @(negedge clk);
        send(periph_pkg::region_time, 11'd0, 4'h0, 32'd0);
        wait_idle();

        send(periph_pkg::region_timer, 11'd0, 4'hf, 32'd5);
        while (!irq) begin
            @(negedge clk);
        end
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        send(periph_pkg::region_timer, 11'd0, 4'h0, 32'd0);
        send(periph_pkg::region_timer, 11'd0, 4'hf, 32'd3);
        repeat (8) @(negedge clk);
        // Mid countdown
        send(periph_pkg::region_timer, 11'd0, 4'h0, 32'd0);
        // Stopped before expiry
        send(periph_pkg::region_timer, 11'd0, 4'hf, 32'd0);
        repeat (60) @(negedge clk);
        wait_idle();

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
